// ==== src/intc_defines.svh ====
`ifndef INTC_DEFINES_SVH
`define INTC_DEFINES_SVH

// number of interrupt sources, a power of two
`define INTC_NUM_SRC 4

`define INTC_PRIO_W 4
`define INTC_VEC_W 32
`define INTC_REG_W 32

// register map
`define INTC_ADDR_MASK  2'd0
`define INTC_ADDR_PRIO  2'd1
`define INTC_ADDR_VBASE 2'd2
`define INTC_ADDR_PEND  2'd3 // read only

`define INTC_VEC_STRIDE 4 // bytes between handler vectors

`endif

// ==== src/intc_pkg.sv ====
`default_nettype none

`include "intc_defines.svh"

package intc_pkg;

  // one bit per source
  typedef logic [`INTC_NUM_SRC-1:0] src_vec_t;

  typedef logic [$clog2(`INTC_NUM_SRC)-1:0] src_id_t;

  typedef logic [`INTC_PRIO_W-1:0] prio_t;

  // source i sits at bits [i*4 +: 4]
  typedef logic [`INTC_NUM_SRC*`INTC_PRIO_W-1:0] prio_table_t;

  typedef logic [`INTC_VEC_W-1:0] vector_t;

  typedef logic [1:0] reg_addr_t;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    SERVE
  } ack_state_t;

endpackage

`default_nettype wire

// ==== src/intc_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "intc_defines.svh"

module intc_regs import intc_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  wire         reg_we,
  input  wire         reg_addr_t reg_addr,
  input  wire  [`INTC_REG_W-1:0] reg_wdata,
  input  wire         src_vec_t pending,
  output logic [`INTC_REG_W-1:0] reg_rdata,
  output src_vec_t    mask,
  output prio_table_t prio_table,
  output vector_t     vector_base
);

  logic wr_mask;
  logic wr_prio;
  logic wr_vbase;

  assign wr_mask  = reg_we && (reg_addr == `INTC_ADDR_MASK);
  assign wr_prio  = reg_we && (reg_addr == `INTC_ADDR_PRIO);
  assign wr_vbase = reg_we && (reg_addr == `INTC_ADDR_VBASE);
  // PEND has no write strobe

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mask <= '1; // everything masked out of reset
      prio_table <= '0;
      vector_base <= '0;
    end else begin
      if (wr_mask) mask <= reg_wdata[`INTC_NUM_SRC-1:0];
      if (wr_prio) prio_table <= reg_wdata[$bits(prio_table_t)-1:0];
      if (wr_vbase) vector_base <= vector_t'(reg_wdata);
    end
  end

  // combinational read back
  always_comb begin
    case (reg_addr)
      `INTC_ADDR_MASK:  reg_rdata = `INTC_REG_W'(mask);
      `INTC_ADDR_PRIO:  reg_rdata = `INTC_REG_W'(prio_table);
      `INTC_ADDR_VBASE: reg_rdata = `INTC_REG_W'(vector_base);
      `INTC_ADDR_PEND:  reg_rdata = `INTC_REG_W'(pending); // live flags
      default:          reg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/irq_source_latch.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "intc_defines.svh"

module irq_source_latch import intc_pkg::*; (
  input  wire      clk,
  input  wire      rst,
  input  wire      src_vec_t src_req,
  input  wire      src_vec_t ack_clear,
  output src_vec_t pending
);

  src_vec_t req_q;   // request lines, registered once
  src_vec_t req_qq;
  src_vec_t rise;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      req_q  <= '0;
      req_qq <= '0;
    end else begin
      req_q  <= src_req;
      req_qq <= req_q;
    end
  end

  assign rise = req_q & ~req_qq;

  // set/reset flags, a fresh edge beats the acknowledge clear
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~ack_clear) | rise;
    end
  end

  // the acknowledge side only ever retires one source at a time
  a_clear_onehot: assert property (
    @(posedge clk) disable iff (rst) $onehot0(ack_clear)
  ) else $error("ack_clear has more than one bit set");

endmodule

`default_nettype wire

// ==== src/irq_prio_resolver.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "intc_defines.svh"

module irq_prio_resolver import intc_pkg::*; (
  input  wire     clk,
  input  wire     rst,
  input  wire     src_vec_t pending,
  input  wire     src_vec_t mask,
  input  wire     prio_table_t prio_table,
  input  wire     prio_t service_level,
  output logic    best_valid,
  output src_id_t best_id,
  output prio_t   best_prio
);

  localparam int N = `INTC_NUM_SRC;
  localparam int W = `INTC_PRIO_W;

  src_vec_t cand;
  prio_t    win_prio;
  src_id_t  win_id;

  assign cand = pending & ~mask; // unmasked requests only

  // comparison tree stored as a heap, leaves hold the sources in index order
  // with four sources this is two levels of compare and select
  always_comb begin : tree
    prio_t   node_prio [2*N-1];
    src_id_t node_id   [2*N-1];

    for (int i = 0; i < N; i++) begin
      node_prio[N-1+i] = cand[i] ? prio_t'(prio_table[i*W +: W]) : '0;
      node_id[N-1+i]   = src_id_t'(i);
    end

    for (int n = N - 2; n >= 0; n--) begin
      // strict greater than, so a tie keeps the left (lower) index
      if (node_prio[2*n+2] > node_prio[2*n+1]) begin
        node_prio[n] = node_prio[2*n+2];
        node_id[n]   = node_id[2*n+2];
      end else begin
        node_prio[n] = node_prio[2*n+1];
        node_id[n]   = node_id[2*n+1];
      end
    end

    win_prio = node_prio[0];
    win_id   = node_id[0];
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      best_valid <= 1'b0;
      best_id    <= '0;
      best_prio  <= '0;
    end else begin
      best_valid <= win_prio > service_level; // level 0 never passes
      best_id    <= win_id;
      best_prio  <= win_prio;
    end
  end

endmodule

`default_nettype wire

// ==== src/irq_ack_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "intc_defines.svh"

module irq_ack_ctrl import intc_pkg::*; (
  input  wire      clk,
  input  wire      rst,
  input  wire      best_valid,
  input  wire      src_id_t best_id,
  input  wire      prio_t best_prio,
  input  wire      vector_t vector_base,
  input  wire      prio_table_t prio_table,
  input  wire      iack,
  input  wire      eoi,
  output logic     irq,
  output vector_t  vector,
  output logic     vector_valid,
  output src_vec_t ack_clear,
  output prio_t    service_level
);

  localparam int N = `INTC_NUM_SRC;
  localparam int W = `INTC_PRIO_W;

  ack_state_t state;
  ack_state_t state_nxt;
  src_vec_t   in_service;
  src_vec_t   eoi_clr;
  src_id_t    top_id;
  logic       top_found;
  logic       winner_ok;
  logic       accept;

  // recheck against the live level, the resolver result is one cycle old
  assign winner_ok = best_valid && (best_prio > service_level);
  assign irq       = (state == REQ) && winner_ok;
  assign accept    = irq && iack;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (winner_ok) state_nxt = REQ;
      REQ: begin
        if (accept) state_nxt = SERVE;
        else if (!winner_ok) state_nxt = IDLE;
      end
      SERVE:   state_nxt = IDLE; // resolver catches up meanwhile
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) state <= IDLE;
    else state <= state_nxt;
  end

  // acknowledge decode, one-hot on the winning source
  assign ack_clear = accept ? (src_vec_t'(1) << best_id) : '0;

  // highest-priority source in service, lower index on a tie
  always_comb begin
    service_level = '0;
    top_id        = '0;
    top_found     = 1'b0;
    for (int i = 0; i < N; i++) begin
      if (in_service[i] && (!top_found || prio_table[i*W +: W] > service_level)) begin
        service_level = prio_t'(prio_table[i*W +: W]);
        top_id        = src_id_t'(i);
        top_found     = 1'b1;
      end
    end
  end

  assign eoi_clr = (eoi && top_found) ? (src_vec_t'(1) << top_id) : '0;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      in_service   <= '0;
      vector_valid <= 1'b0;
    end else begin
      in_service   <= (in_service & ~eoi_clr) | ack_clear;
      vector_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) vector <= vector_base + vector_t'(best_id) * `INTC_VEC_STRIDE;
  end

  a_vv_single: assert property (
    @(posedge clk) disable iff (rst) vector_valid |=> !vector_valid
  ) else $error("vector_valid high two cycles in a row");

  // processor must only answer a raised request
  a_iack_irq: assert property (
    @(posedge clk) disable iff (rst) iack |-> irq
  ) else $error("iack seen while irq low");

endmodule

`default_nettype wire

// ==== src/intc_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "intc_defines.svh"

module intc_top import intc_pkg::*; (
  input  wire     clk,
  input  wire     rst,
  input  wire     src_vec_t src_req,
  input  wire     reg_we,
  input  wire     reg_addr_t reg_addr,
  input  wire     [`INTC_REG_W-1:0] reg_wdata,
  output wire     [`INTC_REG_W-1:0] reg_rdata,
  output wire     irq,
  input  wire     iack,
  output vector_t vector,
  output wire     vector_valid,
  input  wire     eoi
);

  wire src_vec_t    pending;
  wire src_vec_t    mask;
  wire src_vec_t    ack_clear;
  wire prio_table_t prio_table;
  wire vector_t     vector_base;
  wire prio_t       service_level;
  wire              best_valid;
  wire src_id_t     best_id;
  wire prio_t       best_prio;

  intc_regs i_regs (
    .clk         (clk),
    .rst         (rst),
    .reg_we      (reg_we),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .pending     (pending),
    .reg_rdata   (reg_rdata),
    .mask        (mask),
    .prio_table  (prio_table),
    .vector_base (vector_base)
  );

  irq_source_latch i_latch (
    .clk       (clk),
    .rst       (rst),
    .src_req   (src_req),
    .ack_clear (ack_clear),
    .pending   (pending)
  );

  irq_prio_resolver i_resolver (
    .clk           (clk),
    .rst           (rst),
    .pending       (pending),
    .mask          (mask),
    .prio_table    (prio_table),
    .service_level (service_level),
    .best_valid    (best_valid),
    .best_id       (best_id),
    .best_prio     (best_prio)
  );

  irq_ack_ctrl i_ack (
    .clk           (clk),
    .rst           (rst),
    .best_valid    (best_valid),
    .best_id       (best_id),
    .best_prio     (best_prio),
    .vector_base   (vector_base),
    .prio_table    (prio_table),
    .iack          (iack),
    .eoi           (eoi),
    .irq           (irq),
    .vector        (vector),
    .vector_valid  (vector_valid),
    .ack_clear     (ack_clear),
    .service_level (service_level)
  );

endmodule

`default_nettype wire

// ==== tb/intc_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "intc_defines.svh"

module intc_tb;

  localparam int CLK_PERIOD = 20;
  localparam int MAX_STEPS  = 64;
  localparam int IRQ_WAIT   = 40; // cycles allowed for irq ahead of an acknowledge
  localparam int NS = `INTC_NUM_SRC;
  localparam int PW = `INTC_PRIO_W;

  localparam int OP_WR   = 1;
  localparam int OP_RD   = 2;
  localparam int OP_REQ  = 3;
  localparam int OP_ACK  = 4;
  localparam int OP_EOI  = 5;
  localparam int OP_IDLE = 6;
  localparam int OP_DONE = 7;

  logic          clk = 1'b0;
  logic          rst;
  logic [NS-1:0] src_req;
  logic          reg_we;
  logic [1:0]    reg_addr;
  logic [31:0]   reg_wdata;
  logic          iack;
  logic          eoi;
  wire  [31:0]   reg_rdata;
  wire           irq;
  wire  [31:0]   vector;
  wire           vector_valid;

  // reference model state
  logic [NS-1:0]    m_mask;
  logic [NS*PW-1:0] m_prio;
  logic [31:0]      m_base;
  logic [NS-1:0]    m_pend;
  logic [NS-1:0]    m_insvc;

  logic [31:0] pat [0:3*MAX_STEPS-1];
  int          n_steps = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  integer      seed;

  intc_top i_dut (
    .clk          (clk),
    .rst          (rst),
    .src_req      (src_req),
    .reg_we       (reg_we),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .irq          (irq),
    .iack         (iack),
    .vector       (vector),
    .vector_valid (vector_valid),
    .eoi          (eoi)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  function automatic logic [PW-1:0] prio_of(input int i);
    return m_prio[i*PW +: PW];
  endfunction

  function automatic logic [PW-1:0] model_level();
    logic [PW-1:0] lvl;
    lvl = '0;
    for (int i = 0; i < NS; i++) begin
      if (m_insvc[i] && prio_of(i) > lvl) lvl = prio_of(i);
    end
    return lvl;
  endfunction

  // best unmasked pending source above the service level or -1
  function automatic int model_winner();
    int            best;
    logic [PW-1:0] bp;
    best = -1;
    bp   = model_level();
    for (int i = 0; i < NS; i++) begin
      if (m_pend[i] && !m_mask[i] && prio_of(i) > bp) begin // ascending scan keeps lower index
        best = i;
        bp   = prio_of(i);
      end
    end
    return best;
  endfunction

  function automatic void retire_top();
    int top;
    top = -1;
    for (int i = 0; i < NS; i++) begin
      if (m_insvc[i] && (top < 0 || prio_of(i) > prio_of(top))) top = i;
    end
    if (top >= 0) m_insvc[top] = 1'b0;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1: return "reset and registers";
      2: return "masking and priority 0";
      3: return "single interrupt";
      4: return "priority and ties";
      5: return "nesting";
      6: return "edge during clear";
      default: return "unnamed";
    endcase
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    test_errors++;
    errors++;
  endtask

  task automatic note_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    test_errors++;
    errors++;
  endtask

  task automatic check_irq(input logic exp, input string where);
    if (irq !== exp) report_mismatch({where, ": irq vs pattern"}, 32'(irq), 32'(exp));
    if (irq !== (model_winner() >= 0))
      report_mismatch({where, ": irq vs model"}, 32'(irq), 32'(model_winner() >= 0));
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
    @(posedge clk);
    reg_we    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_we <= 1'b0;
    case (addr)
      `INTC_ADDR_MASK:  m_mask = data[NS-1:0];
      `INTC_ADDR_PRIO:  m_prio = data[NS*PW-1:0];
      `INTC_ADDR_VBASE: m_base = data;
      default: ; // PEND is read only
    endcase
    @(negedge clk);
  endtask

  task automatic read_reg_check(input logic [1:0] addr, input logic [31:0] exp);
    @(posedge clk);
    reg_addr <= addr;
    @(negedge clk);
    if (reg_rdata !== exp) report_mismatch("register read", reg_rdata, exp);
    if (addr == `INTC_ADDR_PEND && reg_rdata !== 32'(m_pend))
      report_mismatch("PEND vs model", reg_rdata, 32'(m_pend));
  endtask

  // irq reacts four edges after the drive edge, through the input register,
  // the pending flag, the resolver register and the FSM
  task automatic pulse_request(input logic [NS-1:0] lines, input logic exp);
    logic irq_before;
    irq_before = irq;
    @(posedge clk);
    src_req <= lines;
    @(posedge clk);
    src_req <= '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (irq !== irq_before) report_mismatch("irq ahead of latency", 32'(irq), 32'(irq_before));
    @(negedge clk);
    m_pend = m_pend | lines;
    check_irq(exp, "request");
  endtask

  // lines get their edge in the same cycle as the acknowledge clear
  task automatic acknowledge(input logic [NS-1:0] lines, input logic [31:0] exp_vec);
    int            n;
    int            win;
    logic [NS-1:0] won;
    for (n = 0; n < IRQ_WAIT && irq !== 1'b1; n++) @(negedge clk);
    win = model_winner();
    if (irq !== 1'b1) begin
      note_failure("irq never rose, nothing to acknowledge");
    end else if (win < 0) begin
      note_failure("irq is high but the model has no source to serve");
    end else begin
      won      = '0;
      won[win] = 1'b1;
      @(posedge clk);
      src_req <= lines;
      @(posedge clk);
      src_req <= '0;
      iack    <= 1'b1;
      @(posedge clk);
      iack <= 1'b0;
      @(negedge clk);
      if (vector_valid !== 1'b1) begin
        note_failure("vector_valid missing one cycle after iack");
      end else begin
        if (vector !== exp_vec) report_mismatch("vector vs pattern", vector, exp_vec);
        if (vector !== m_base + 32'(win) * `INTC_VEC_STRIDE)
          report_mismatch("vector vs model", vector, m_base + 32'(win) * `INTC_VEC_STRIDE);
      end
      m_pend  = (m_pend & ~won) | lines;
      m_insvc = m_insvc | won;
      @(negedge clk);
      if (vector_valid !== 1'b0) note_failure("vector_valid stayed high a second cycle");
    end
  endtask

  task automatic end_of_interrupt(input logic exp);
    @(posedge clk);
    eoi <= 1'b1;
    @(posedge clk);
    eoi <= 1'b0;
    retire_top();
    repeat (3) @(posedge clk); // level, resolver and FSM settle
    @(negedge clk);
    check_irq(exp, "eoi");
  endtask

  task automatic idle_cycles(input int cycles, input logic exp);
    repeat (cycles) @(negedge clk);
    check_irq(exp, "idle");
    if (vector_valid !== 1'b0) note_failure("vector_valid high without an acknowledge");
  endtask

  task automatic finish_test(input int id);
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %0d %s: ok", id, test_name(id));
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", id, test_name(id), test_errors);
    end
    test_errors = 0;
  endtask

  initial begin
    int          op;
    int          gap;
    logic [31:0] arg;
    logic [31:0] expv;
    seed      = 32'h5e939e79;
    rst       = 1'b1;
    src_req   = '0;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    iack      = 1'b0;
    eoi       = 1'b0;
    m_mask    = '1;
    m_prio    = '0;
    m_base    = '0;
    m_pend    = '0;
    m_insvc   = '0;
    $readmemh("tb/intc_patterns.txt", pat);
    while (n_steps < MAX_STEPS && pat[3*n_steps] != 32'd0) n_steps++;
    if (n_steps == 0) note_failure("pattern file is missing or empty");
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (irq !== 1'b0) note_failure("irq high after reset");
    if (vector_valid !== 1'b0) note_failure("vector_valid high after reset");
    for (int k = 0; k < n_steps; k++) begin
      op   = int'(pat[3*k]);
      arg  = pat[3*k+1];
      expv = pat[3*k+2];
      case (op)
        OP_WR:   write_reg(arg[1:0], expv);
        OP_RD:   read_reg_check(arg[1:0], expv);
        OP_REQ:  pulse_request(arg[NS-1:0], expv[0]);
        OP_ACK:  acknowledge(arg[NS-1:0], expv);
        OP_EOI:  end_of_interrupt(expv[0]);
        OP_IDLE: idle_cycles(int'(arg), expv[0]);
        OP_DONE: finish_test(int'(arg));
        default: note_failure("unknown opcode in pattern file");
      endcase
      gap = {$random(seed)} % 4;
      repeat (gap) @(negedge clk);
    end
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    wait (n_steps > 0);
    @(negedge rst); // step count is complete by the end of reset
    #(n_steps * 40 * CLK_PERIOD);
    $display("timeout, the run did not finish within its time budget");
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/intc_patterns.txt ====
// op arg value: 1 write addr data, 2 read addr expected, 3 request lines irq, 7 test done id
// 4 iack with lines edged in the clear cycle and vector, 5 eoi irq, 6 idle cycles irq, 0 end
// reset values and register access
2 0 0000000f
2 1 00000000
2 2 00000000
2 3 00000000
1 2 80001000
2 2 80001000
1 3 0000000f
2 3 00000000
7 1 0
// source 2 masked, source 3 unmasked at priority 0
1 1 00000332
2 1 00000332
1 0 00000007
3 c 0
2 3 0000000c
7 2 0
// single interrupt on source 0
1 0 00000006
3 1 1
4 0 80001000
2 3 0000000c
5 0 0
7 3 0
// sources 1 and 2 tie at priority 3, source 0 follows
1 0 00000000
6 4 1
3 3 1
4 0 80001004
5 0 1
4 0 80001008
5 0 1
4 0 80001000
5 0 0
2 3 00000008
7 4 0
// nesting with source 0 in service
1 1 00000232
3 1 1
4 0 80001000
3 4 0
3 2 1
4 0 80001004
5 0 0
5 0 1
4 0 80001008
5 0 0
7 5 0
// new edge on source 1 while it is acknowledged
3 2 1
4 2 80001004
2 3 0000000a
5 0 1
4 0 80001004
5 0 0
7 6 0
0 0 0

// ==== src.f ====
+incdir+src
src/intc_pkg.sv
src/intc_regs.sv
src/irq_source_latch.sv
src/irq_prio_resolver.sv
src/irq_ack_ctrl.sv
src/intc_top.sv
tb/intc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= intc_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for a pass"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "sim passed"

clean:
	rm -rf $(BUILD_DIR)
